//--- sources.f
+incdir+src
+incdir+verification
src/reconPkg.sv
src/fwdTransform.sv
src/quantizer.sv
src/invTransform.sv
src/lumaRecon.sv
verification/lumaRecon_tb.sv

//--- Makefile
# Verilator simulation of the luma residual coding pipeline

VERILATOR ?= verilator
TOP       ?= lumaRecon_tb
SEED      ?= 79
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/reconModel.svh
/*
 * Reference model for the luma pipeline testbench
 * Forward DCT, quantizer and inverse DCT with reconstruction
 */
`ifndef RECON_MODEL_SVH
`define RECON_MODEL_SVH

function automatic int scaleK1(input int x);
    return x + int'((longint'(x) * 20091) >>> 16);
endfunction

function automatic int scaleK2(input int x);
    return int'((longint'(x) * 35468) >>> 16);
endfunction

function automatic logic [7:0] clip8(input int v);
    if (v < 0) begin
        return 8'd0;
    end
    return (v > 255) ? 8'd255 : 8'(v);
endfunction

// Residual and forward DCT, rows first then columns
function automatic coefBlock_t fwdDct(input pixBlock_t src, input pixBlock_t pred);
    int r [16];
    int d [4];
    int a0, a1, a2, a3;
    coefBlock_t c;
    for (int y = 0; y < 4; y++) begin
        for (int k = 0; k < 4; k++) begin
            d[k] = int'(src[4*y+k]) - int'(pred[4*y+k]);
        end
        a0 = d[0] + d[3];
        a1 = d[1] + d[2];
        a2 = d[1] - d[2];
        a3 = d[0] - d[3];
        r[4*y+0] = (a0 + a1) * 8;
        r[4*y+2] = (a0 - a1) * 8;
        r[4*y+1] = (a2 * 2217 + a3 * 5352 + 1812) >>> 9;
        r[4*y+3] = (a3 * 2217 - a2 * 5352 + 937) >>> 9;
    end
    for (int x = 0; x < 4; x++) begin
        a0 = r[x] + r[12+x];
        a1 = r[4+x] + r[8+x];
        a2 = r[4+x] - r[8+x];
        a3 = r[x] - r[12+x];
        c[x]    = coef_t'((a0 + a1 + 7) >>> 4);
        c[8+x]  = coef_t'((a0 - a1 + 7) >>> 4);
        c[4+x]  = coef_t'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + ((a3 != 0) ? 1 : 0));
        c[12+x] = coef_t'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
    end
    return c;
endfunction

function automatic reconOut_t modelBlock(input reconIn_t blk, input quantCfg_t cfg);
    coefBlock_t c;
    coefBlock_t deq;
    reconOut_t  res;
    int         q, iq, bias, v, mag, level, dc, a, b, cc, dd;
    longint     lv;
    int         t [4][4];
    int         o [4];
    c = fwdDct(blk.src, blk.pred);
    res.nonzero = 1'b0;
    for (int i = 0; i < 16; i++) begin
        q    = (i == 0) ? int'(cfg.dcQ) : int'(cfg.acQ);
        iq   = (i == 0) ? int'(cfg.dcIq) : int'(cfg.acIq);
        bias = (i == 0) ? int'(cfg.dcBias) : int'(cfg.acBias);
        v    = int'($signed(c[i]));
        mag  = (v < 0) ? -v : v;
        lv   = (longint'(mag) * longint'(iq) + (longint'(bias) << 8)) >>> 17;
        if (lv > 2047) begin
            lv = 2047;
        end
        level = (v < 0) ? -int'(lv) : int'(lv);
        res.levels[i] = coef_t'(level);
        deq[i]        = coef_t'(level * q);
        res.nonzero   = res.nonzero | (level != 0);
    end
    // Vertical pass per column
    for (int i = 0; i < 4; i++) begin
        a  = int'($signed(deq[i])) + int'($signed(deq[8+i]));
        b  = int'($signed(deq[i])) - int'($signed(deq[8+i]));
        cc = scaleK2(int'($signed(deq[4+i]))) - scaleK1(int'($signed(deq[12+i])));
        dd = scaleK1(int'($signed(deq[4+i]))) + scaleK2(int'($signed(deq[12+i])));
        t[i][0] = a + dd;
        t[i][1] = b + cc;
        t[i][2] = b - cc;
        t[i][3] = a - dd;
    end
    // Horizontal pass per row, then prediction add
    for (int y = 0; y < 4; y++) begin
        dc = t[0][y] + 4;
        a  = dc + t[2][y];
        b  = dc - t[2][y];
        cc = scaleK2(t[1][y]) - scaleK1(t[3][y]);
        dd = scaleK1(t[1][y]) + scaleK2(t[3][y]);
        o[0] = a + dd;
        o[1] = b + cc;
        o[2] = b - cc;
        o[3] = a - dd;
        for (int x = 0; x < 4; x++) begin
            res.recon[4*y+x] = clip8(int'(blk.pred[4*y+x]) + (o[x] >>> 3));
        end
    end
    return res;
endfunction

`endif

//--- verification/lumaRecon_tb.sv
/*
 * Testbench for the luma residual coding pipeline
 * Random and extreme blocks, back-to-back and stalled output,
 * scoreboard against the reference model
 */
`timescale 1ns/1ps

module lumaRecon_tb #(
    parameter int SEED = 79
);
    import reconPkg::*;

    `include "reconModel.svh"

    localparam int NUM_BLOCKS   = 125;
    localparam int STALL_CYCLES = 300;
    localparam int CYCLE_LIMIT  = 4 * NUM_BLOCKS + STALL_CYCLES + 50;

    logic      clk;
    logic      rst_n;
    logic      inValid;
    logic      inReady;
    reconIn_t  inData;
    logic      outValid;
    logic      outReady;
    reconOut_t outData;
    quantCfg_t quantCfg;

    int        seed;
    reconOut_t expQ[$];
    int        acceptQ[$];
    int        cycleCount;
    int        outCount;
    bit        strictTiming;
    bit        randomStall;
    reconOut_t lastOut;
    reconIn_t  blk;

    lumaRecon dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData),
        .quantCfg (quantCfg)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic failValue(input string msg);
        stopRun($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    function automatic reconIn_t randBlock();
        reconIn_t b;
        for (int i = 0; i < 16; i++) begin
            b.src[i]  = 8'($random(seed));
            b.pred[i] = 8'($random(seed));
        end
        return b;
    endfunction

    function automatic quantCfg_t randCfg();
        quantCfg_t c;
        c.dcQ    = 16'(1 + ($random(seed) & 63));
        c.dcIq   = 16'($random(seed));
        c.dcBias = 16'($random(seed));
        c.acQ    = 16'(1 + ($random(seed) & 63));
        c.acIq   = 16'($random(seed));
        c.acBias = 16'($random(seed));
        return c;
    endfunction

    // Starts at a falling edge and returns at the one after the transfer
    task automatic sendBlock(input reconIn_t b);
        inValid = 1'b1;
        inData  = b;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard and cycle limit
    // ------------------------------------------------------------------------
    always @(posedge clk) begin : scoreboard
        reconOut_t expBlk;
        int        acceptedAt;
        if (rst_n) begin
            if (inValid && inReady) begin
                expQ.push_back(modelBlock(inData, quantCfg));
                acceptQ.push_back(cycleCount);
            end
            assert (inReady || (dut0.fwdValid && dut0.quantValid && outValid))
                else failValue("inReady low before the pipeline filled");
            if (outValid && outReady) begin
                assert (expQ.size() > 0)
                    else stopRun("Output transfer with no block outstanding");
                expBlk     = expQ.pop_front();
                acceptedAt = acceptQ.pop_front();
                assert (outData === expBlk)
                    else failValue($sformatf("block %0d output differs from model", outCount));
                assert (!strictTiming || cycleCount - acceptedAt == 3)
                    else failValue($sformatf("block %0d latency %0d cycles", outCount,
                                             cycleCount - acceptedAt));
                lastOut = outData;
                outCount++;
            end
        end
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            stopRun("Timeout: the cycle limit was reached before all blocks came out");
        end
    end

    // Output must hold while stalled
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rst_n)
        (outValid && !outReady) |=> (outValid && $stable(outData)))
        else failValue("outData changed or dropped during a stall");

    always @(negedge clk) begin
        if (randomStall) begin
            outReady = 1'($random(seed));
        end
    end

    initial begin
        seed         = SEED;
        rst_n        = 1'b0;
        inValid      = 1'b0;
        inData       = '0;
        outReady     = 1'b1;
        quantCfg     = '0;
        cycleCount   = 0;
        outCount     = 0;
        strictTiming = 1'b1;
        randomStall  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!outValid && inReady)
            else failValue("outValid or inReady wrong after reset");

        // Source equals prediction
        quantCfg = '{dcQ: 16'd8, dcIq: 16'd16384, dcBias: 16'd0,
                     acQ: 16'd8, acIq: 16'd16384, acBias: 16'd0};
        blk      = randBlock();
        blk.src  = blk.pred;
        sendBlock(blk);
        drain();
        assert (lastOut.levels == '0 && !lastOut.nonzero && lastOut.recon == blk.pred)
            else failValue("zero residual block not reconstructed as prediction");

        // Random runs with one config each
        for (int run = 0; run < 5; run++) begin
            quantCfg = randCfg();
            for (int n = 0; n < 8; n++) begin
                sendBlock(randBlock());
            end
            drain();
        end

        // Back-to-back
        for (int n = 0; n < 20; n++) begin
            sendBlock(randBlock());
        end
        drain();

        // Random output stalls
        strictTiming = 1'b0;
        randomStall  = 1'b1;
        for (int n = 0; n < 60; n++) begin
            sendBlock(randBlock());
        end
        drain();
        randomStall  = 1'b0;
        outReady     = 1'b1;
        drain();
        strictTiming = 1'b1;

        // Extreme residuals with small then large quantizer steps
        for (int k = 0; k < 4; k++) begin
            if (k < 2) begin
                quantCfg = '{dcQ: 16'd1, dcIq: 16'd3, dcBias: 16'd0,
                             acQ: 16'd2, acIq: 16'd5, acBias: 16'd0};
            end else begin
                quantCfg = '{dcQ: 16'd40, dcIq: 16'hffff, dcBias: 16'hffff,
                             acQ: 16'd30, acIq: 16'hffff, acBias: 16'hffff};
            end
            blk.src  = (k % 2 == 0) ? '1 : '0;
            blk.pred = (k % 2 == 0) ? '0 : '1;
            sendBlock(blk);
            drain();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src/lumaRecon.sv
/*
 * Luma 4x4 residual coding pipeline, top level
 * Forward DCT, quantizer and inverse DCT chained over valid/ready,
 * three cycles from input transfer to output valid
 */
`timescale 1ns/1ps

module lumaRecon (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inValid,
    output logic                inReady,
    input  reconPkg::reconIn_t  inData,
    output logic                outValid,
    input  logic                outReady,
    output reconPkg::reconOut_t outData,
    input  reconPkg::quantCfg_t quantCfg
);
    import reconPkg::*;

    // Forward to quantizer
    logic      fwdValid;
    logic      fwdReady;
    fwdOut_t   fwdData;

    // Quantizer to inverse
    logic      quantValid;
    logic      quantReady;
    quantOut_t quantData;

    fwdTransform fwd0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .outValid (fwdValid),
        .outReady (fwdReady),
        .outData  (fwdData)
    );

    quantizer quant0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (fwdValid),
        .inReady  (fwdReady),
        .inData   (fwdData),
        .quantCfg (quantCfg),
        .outValid (quantValid),
        .outReady (quantReady),
        .outData  (quantData)
    );

    invTransform inv0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (quantValid),
        .inReady  (quantReady),
        .inData   (quantData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

//--- src/invTransform.sv
/*
 * Inverse stage of the luma pipeline
 * VP8 inverse 4x4 DCT on the dequantized block, prediction add
 * and clip to 8 bits, one valid/ready register slot
 */
`timescale 1ns/1ps
`include "reconDefs_defs.svh"

module invTransform (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inValid,
    output logic                inReady,
    input  reconPkg::quantOut_t inData,
    output logic                outValid,
    input  logic                outReady,
    output reconPkg::reconOut_t outData
);
    import reconPkg::*;

    int        vertT [`BLK_N];
    pixBlock_t reconNext;

    function automatic int mul1(input int x);
        longint prod;
        prod = longint'(x) * `IDCT_K1;
        return x + int'(prod >>> 16);
    endfunction

    function automatic int mul2(input int x);
        longint prod;
        prod = longint'(x) * `IDCT_K2;
        return int'(prod >>> 16);
    endfunction

    function automatic logic [`PIX_W-1:0] clipPix(input int val);
        if (val < 0) begin
            return '0;
        end
        if (val > (1 << `PIX_W) - 1) begin
            return '1;
        end
        return val[`PIX_W-1:0];
    endfunction

    // ------------------------------------------------------------------------
    // Vertical pass, column i lands in vertT[4*i +: 4]
    // ------------------------------------------------------------------------
    always_comb begin : vertPass
        int a, b, c, d;
        for (int i = 0; i < 4; i++) begin
            a = int'($signed(inData.dequant[i])) + int'($signed(inData.dequant[8+i]));
            b = int'($signed(inData.dequant[i])) - int'($signed(inData.dequant[8+i]));
            c = mul2(int'($signed(inData.dequant[4+i])))
                - mul1(int'($signed(inData.dequant[12+i])));
            d = mul1(int'($signed(inData.dequant[4+i])))
                + mul2(int'($signed(inData.dequant[12+i])));
            vertT[4*i+0] = a + d;
            vertT[4*i+1] = b + c;
            vertT[4*i+2] = b - c;
            vertT[4*i+3] = a - d;
        end
    end

    // ------------------------------------------------------------------------
    // Horizontal pass, rounding, prediction add
    // ------------------------------------------------------------------------
    always_comb begin : horzPass
        int dc, a, b, c, d;
        int v [4];
        for (int i = 0; i < 4; i++) begin
            dc   = vertT[i] + 4;
            a    = dc + vertT[8+i];
            b    = dc - vertT[8+i];
            c    = mul2(vertT[4+i]) - mul1(vertT[12+i]);
            d    = mul1(vertT[4+i]) + mul2(vertT[12+i]);
            v[0] = a + d;
            v[1] = b + c;
            v[2] = b - c;
            v[3] = a - d;
            for (int x = 0; x < 4; x++) begin
                reconNext[4*i+x] = clipPix(int'(inData.pred[4*i+x]) + (v[x] >>> 3));
            end
        end
    end

    // Register slot
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData.recon   <= reconNext;
            outData.levels  <= inData.levels;
            outData.nonzero <= inData.nonzero;
        end
    end

endmodule

//--- src/quantizer.sv
/*
 * Quantizer stage of the luma pipeline
 * Levels, dequantized coefficients and a block nonzero flag.
 * Coefficient 0 uses the DC fields, the rest the AC fields
 */
`timescale 1ns/1ps
`include "reconDefs_defs.svh"

module quantizer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inValid,
    output logic                inReady,
    input  reconPkg::fwdOut_t   inData,
    input  reconPkg::quantCfg_t quantCfg,
    output logic                outValid,
    input  logic                outReady,
    output reconPkg::quantOut_t outData
);
    import reconPkg::*;

    coefBlock_t levelsNext;
    coefBlock_t dequantNext;
    logic       anyNz;

    always_comb begin : quantize
        logic [`COEF_W-1:0] mag;
        logic [`COEF_W-1:0] q;
        logic [`COEF_W-1:0] iq;
        logic [`COEF_W-1:0] bias;
        logic [35:0]        scaled;
        logic [35:0]        qdiv;
        int                 level;
        anyNz = 1'b0;
        for (int i = 0; i < `BLK_N; i++) begin
            q    = (i == 0) ? quantCfg.dcQ    : quantCfg.acQ;
            iq   = (i == 0) ? quantCfg.dcIq   : quantCfg.acIq;
            bias = (i == 0) ? quantCfg.dcBias : quantCfg.acBias;
            mag  = inData.coef[i][`COEF_W-1] ? -inData.coef[i] : inData.coef[i];

            scaled = 36'(mag) * 36'(iq) + (36'(bias) << 8);
            qdiv   = scaled >> `QFIX;
            level  = (qdiv > 36'(`MAX_LEVEL)) ? `MAX_LEVEL : int'(qdiv);
            // Restore sign
            if (inData.coef[i][`COEF_W-1]) begin
                level = -level;
            end

            levelsNext[i]  = coef_t'(level);
            dequantNext[i] = coef_t'(level * int'(q));
            anyNz          = anyNz | (level != 0);
        end
    end

    // ------------------------------------------------------------------------
    // Register slot
    // ------------------------------------------------------------------------
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData.levels  <= levelsNext;
            outData.dequant <= dequantNext;
            outData.pred    <= inData.pred;
            outData.nonzero <= anyNz;
        end
    end

endmodule

//--- src/fwdTransform.sv
/*
 * Forward stage of the luma pipeline
 * Residual of source and prediction, VP8 integer 4x4 DCT,
 * one valid/ready register slot
 */
`timescale 1ns/1ps
`include "reconDefs_defs.svh"

module fwdTransform (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inValid,
    output logic               inReady,
    input  reconPkg::reconIn_t inData,
    output logic               outValid,
    input  logic               outReady,
    output reconPkg::fwdOut_t  outData
);
    import reconPkg::*;

    int         rowT [`BLK_N];
    coefBlock_t coefNext;

    // ------------------------------------------------------------------------
    // Horizontal pass on the residual
    // ------------------------------------------------------------------------
    always_comb begin : rowPass
        int d0, d1, d2, d3;
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            d0 = int'(inData.src[4*r+0]) - int'(inData.pred[4*r+0]);
            d1 = int'(inData.src[4*r+1]) - int'(inData.pred[4*r+1]);
            d2 = int'(inData.src[4*r+2]) - int'(inData.pred[4*r+2]);
            d3 = int'(inData.src[4*r+3]) - int'(inData.pred[4*r+3]);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            rowT[4*r+0] = (a0 + a1) * 8;
            rowT[4*r+1] = (a2 * `DCT_C1 + a3 * `DCT_C2 + 1812) >>> 9;
            rowT[4*r+2] = (a0 - a1) * 8;
            rowT[4*r+3] = (a3 * `DCT_C1 - a2 * `DCT_C2 + 937) >>> 9;
        end
    end

    // ------------------------------------------------------------------------
    // Vertical pass
    // ------------------------------------------------------------------------
    always_comb begin : colPass
        int a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = rowT[c] + rowT[12+c];
            a1 = rowT[4+c] + rowT[8+c];
            a2 = rowT[4+c] - rowT[8+c];
            a3 = rowT[c] - rowT[12+c];
            coefNext[c]    = coef_t'((a0 + a1 + 7) >>> 4);
            // Rounding nudge on the first odd row
            coefNext[4+c]  = coef_t'(((a2 * `DCT_C1 + a3 * `DCT_C2 + 12000) >>> 16)
                                     + ((a3 != 0) ? 1 : 0));
            coefNext[8+c]  = coef_t'((a0 - a1 + 7) >>> 4);
            coefNext[12+c] = coef_t'((a3 * `DCT_C1 - a2 * `DCT_C2 + 51000) >>> 16);
        end
    end

    // ------------------------------------------------------------------------
    // Register slot
    // ------------------------------------------------------------------------
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData.coef <= coefNext;
            outData.pred <= inData.pred;
        end
    end

endmodule

//--- src/reconPkg.sv
/*
 * Shared types for the luma residual coding pipeline
 * Pixel and coefficient blocks plus the per-stage payload structs
 */
`include "reconDefs_defs.svh"

package reconPkg;

    typedef logic signed [`COEF_W-1:0] coef_t;

    // Raster order, index 0 is top-left
    typedef logic [`BLK_N-1:0][`PIX_W-1:0] pixBlock_t;
    typedef coef_t [`BLK_N-1:0] coefBlock_t;

    typedef struct packed {
        pixBlock_t src;
        pixBlock_t pred;
    } reconIn_t;

    // Bias fields are scaled by 256 inside the quantizer
    typedef struct packed {
        logic [`COEF_W-1:0] dcQ;
        logic [`COEF_W-1:0] dcIq;
        logic [`COEF_W-1:0] dcBias;
        logic [`COEF_W-1:0] acQ;
        logic [`COEF_W-1:0] acIq;
        logic [`COEF_W-1:0] acBias;
    } quantCfg_t;

    typedef struct packed {
        coefBlock_t coef;
        pixBlock_t  pred;
    } fwdOut_t;

    typedef struct packed {
        coefBlock_t levels;
        coefBlock_t dequant;
        pixBlock_t  pred;
        logic       nonzero;
    } quantOut_t;

    typedef struct packed {
        pixBlock_t  recon;
        coefBlock_t levels;
        logic       nonzero;
    } reconOut_t;

endpackage

//--- src/reconDefs_defs.svh
/*
 * Luma residual coding pipeline constants
 * Widths, VP8 transform multipliers and quantizer limits
 */
`ifndef RECON_DEFS_SVH
`define RECON_DEFS_SVH

// Widths
`define PIX_W     8
`define COEF_W    16
`define BLK_N     16

// Forward DCT multipliers
`define DCT_C1    2217
`define DCT_C2    5352

// Inverse DCT multipliers, 16-bit fixed point
`define IDCT_K1   20091
`define IDCT_K2   35468

// Quantizer
`define QFIX      17
`define MAX_LEVEL 2047

`endif
